//--- compile.f
verilog/bpu_pkg.sv
verilog/bpf.sv
verilog/bht.sv
verilog/btb.sv
verilog/bpu_ctrl.sv
verilog/bpu_top.sv
verif/tb_bpu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the branch prediction testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_bpu_top -o sim \
	&& ./obj_dir/sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1

//--- verif/tb_bpu_top.sv
/*
 * Testbench for the branch prediction unit: clock and reset,
 * directed and random resolve and lookup stimulus, table reference model,
 * immediate and concurrent assertions, timeout
 */

`default_nettype none

module tb_bpu_top;

	import bpu_pkg::*;

	localparam int IDX_W   = DEFAULT_IDX_W;
	localparam int ENTRIES = 2 ** IDX_W;
	// About four times the expected run of roughly 1000 cycles
	localparam int CYCLE_LIMIT = 4000;

	logic         clk = 1'b0;
	logic         arst_n_i;
	logic         lookup_req_i;
	logic [31:0]  lookup_pc_i;
	logic         predict_valid_o;
	bpu_predict_t predict_o;
	bpu_resolve_t resolve_i;
	logic         stall_i;
	logic         csr_flush_i;
	logic [31:0]  csr_target_i;
	bpu_update_t  update_o;
	logic [31:0]  pc_link_o;
	logic         ready_o;

	int err_cnt = 0;
	int prop_errs = 0;
	int cycles = 0;
	logic flush_pending = 1'b0;

	// Table model
	logic [1:0]       m_cnt [ENTRIES];
	logic             m_valid [ENTRIES];
	logic [29-IDX_W:0] m_tag [ENTRIES];
	logic [29:0]      m_tgt [ENTRIES];
	br_class_t        m_cls [ENTRIES];

	bpu_top i_bpu_top (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.lookup_req_i    (lookup_req_i),
		.lookup_pc_i     (lookup_pc_i),
		.predict_valid_o (predict_valid_o),
		.predict_o       (predict_o),
		.resolve_i       (resolve_i),
		.stall_i         (stall_i),
		.csr_flush_i     (csr_flush_i),
		.csr_target_i    (csr_target_i),
		.update_o        (update_o),
		.pc_link_o       (pc_link_o),
		.ready_o         (ready_o)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the test sequence did not complete", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// Nothing predicted or flushed during the clear sweep
	assert property (@(posedge clk) disable iff (!arst_n_i)
		!ready_o |-> !predict_valid_o && !update_o.flush)
	else begin
		prop_errs++;
		$display("FAIL t=%0t: prediction or flush while the tables are clearing", $time);
	end

	assert property (@(posedge clk) pc_link_o == resolve_i.pc + 32'd4)
	else begin
		prop_errs++;
		$display("FAIL t=%0t: pc_link_o is %h, expected pc+4", $time, pc_link_o);
	end

	task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("FAIL t=%0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// Reference rules
	// ------------------------------------------------------------
	function automatic logic taken_of(bpu_resolve_t r);
		logic [31:0] sj;
		logic [31:0] sd;
		logic        res;
		// Flipping the sign bit turns signed order into unsigned order
		sj = r.rj ^ 32'h8000_0000;
		sd = r.rd ^ 32'h8000_0000;
		res = 1'b0;
		if (r.branch_type == BRANCH_IMMEDIATE || r.branch_type == BRANCH_INDIRECT) begin
			res = 1'b1;
		end else if (r.branch_type == BRANCH_CONDITION) begin
			case (r.cmp_type)
				CMP_EQL: res = r.rj == r.rd;
				CMP_NEQ: res = r.rj != r.rd;
				CMP_LSS: res = sj < sd;
				CMP_GER: res = sd < sj;
				CMP_LEQ: res = !(sd < sj);
				CMP_GEQ: res = !(sj < sd);
				CMP_LTU: res = r.rj < r.rd;
				default: res = !(r.rj < r.rd);
			endcase
		end
		return res;
	endfunction

	function automatic logic [31:0] target_of(bpu_resolve_t r);
		logic [31:0] off16;
		logic [31:0] off26;
		off16 = {{14{r.inst25_0[25]}}, r.inst25_0[25:10], 2'b00};
		off26 = {{4{r.inst25_0[9]}}, r.inst25_0[9:0], r.inst25_0[25:10], 2'b00};
		if (r.branch_type == BRANCH_IMMEDIATE) begin
			return r.pc + off26;
		end else if (r.branch_type == BRANCH_INDIRECT) begin
			return r.rj + off16;
		end else if (r.branch_type == BRANCH_CONDITION && taken_of(r)) begin
			return r.pc + off16;
		end
		return (r.pc & ~32'h7) + 32'd8;
	endfunction

	function automatic br_class_t class_of(bpu_resolve_t r);
		logic ind;
		ind = r.branch_type == BRANCH_INDIRECT;
		if ((ind && r.inst25_0[4:0] == 5'd1) || r.branch_link) begin
			return BR_CALL;
		end else if (ind && r.inst25_0[9:5] == 5'd1 && r.inst25_0[25:10] == 16'd0) begin
			return BR_RETURN;
		end else if (ind || r.branch_type == BRANCH_IMMEDIATE) begin
			return BR_ABSOLUTE;
		end
		return BR_PC_RELATIVE;
	endfunction

	function automatic bpu_predict_t table_predict(logic [31:0] pc);
		bpu_predict_t p;
		int           idx;
		idx = int'(pc[IDX_W+1:2]);
		p.hit = m_valid[idx] && m_tag[idx] == pc[31:IDX_W+2];
		p.taken = p.hit && m_cnt[idx] >= 2'd2;
		p.npc = p.taken ? m_tgt[idx] : 30'(((pc & ~32'h7) + 32'd8) >> 2);
		p.br_class = m_cls[idx];
		return p;
	endfunction

	// ------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------
	function automatic bpu_resolve_t random_branch(branch_type_t kind);
		bpu_resolve_t r;
		logic [31:0]  tgt;
		r.valid = 1'b1;
		r.pc = $urandom & ~32'h3;
		r.rj = ($urandom_range(4) == 0) ? 32'h7FFF_FFFF : $urandom;
		case ($urandom_range(3))
			0: r.rd = r.rj;
			1: r.rd = r.rj ^ 32'h8000_0000;
			2: r.rd = ($urandom_range(1) == 0) ? 32'h0 : 32'hFFFF_FFFF;
			default: r.rd = $urandom;
		endcase
		r.inst25_0 = 26'($urandom);
		r.branch_type = kind;
		r.cmp_type = cmp_type_t'(3'($urandom));
		r.branch_link = 1'b0;
		r.predict.hit = 1'b0;
		r.predict.br_class = BR_PC_RELATIVE;
		r.predict.taken = 1'($urandom);
		tgt = target_of(r);
		r.predict.npc = ($urandom_range(1) == 0) ? tgt[31:2] : 30'($urandom);
		return r;
	endfunction

	// BEQ at pc with a +0x40 offset and the table's own prediction
	function automatic bpu_resolve_t eq_branch(logic [31:0] pc, logic taken);
		bpu_resolve_t r;
		r = '0;
		r.valid = 1'b1;
		r.pc = pc;
		r.rj = 32'd5;
		r.rd = taken ? 32'd5 : 32'd6;
		r.inst25_0 = {16'h0010, 10'd0};
		r.branch_type = BRANCH_CONDITION;
		r.cmp_type = CMP_EQL;
		r.predict = table_predict(pc);
		return r;
	endfunction

	task automatic resolve_branch(bpu_resolve_t r, logic stall, logic csr, logic [31:0] csr_tgt);
		logic        taken;
		logic [31:0] tgt;
		logic [29:0] exp_tgt;
		logic        miss;
		logic        qual;
		int          idx;
		@(negedge clk);
		lookup_req_i = 1'b0;
		resolve_i = r;
		stall_i = stall;
		csr_flush_i = csr;
		csr_target_i = csr_tgt;
		taken = taken_of(r);
		tgt = target_of(r);
		qual = r.valid && !stall;
		miss = (r.predict.taken != taken) || (r.predict.taken && r.predict.npc != tgt[31:2]);
		if (csr) begin
			exp_tgt = csr_tgt[31:2];
		end else if (!r.pc[2] && r.predict.taken && !taken) begin
			exp_tgt = r.pc[31:2] + 30'd1;
		end else begin
			exp_tgt = tgt[31:2];
		end
		#10;
		check_value("br_taken", 32'(update_o.br_taken), 32'(taken));
		check_value("flush", 32'(update_o.flush), 32'((qual && miss) || csr));
		check_value("br_target", 32'(update_o.br_target), 32'(exp_tgt));
		check_value("br_class", 32'(update_o.br_class), 32'(class_of(r)));
		check_value("write", 32'(update_o.write), 32'(qual && r.branch_type != BRANCH_INVALID));
		check_value("update pc", {update_o.pc, 2'b00}, r.pc & ~32'h3);
		flush_pending = (qual && miss) || csr;
		@(posedge clk);
		if (qual && r.branch_type != BRANCH_INVALID) begin
			idx = int'(r.pc[IDX_W+1:2]);
			if (taken && m_cnt[idx] != 2'd3) begin
				m_cnt[idx] = m_cnt[idx] + 2'd1;
			end else if (!taken && m_cnt[idx] != 2'd0) begin
				m_cnt[idx] = m_cnt[idx] - 2'd1;
			end
			if (taken && !csr) begin
				m_valid[idx] = 1'b1;
				m_tag[idx] = r.pc[31:IDX_W+2];
				m_tgt[idx] = exp_tgt;
				m_cls[idx] = class_of(r);
			end
		end
	endtask

	// A lookup in the cycle right after a flush must be dropped
	task automatic lookup_check(logic [31:0] pc);
		bpu_predict_t exp;
		logic         exp_valid;
		@(negedge clk);
		resolve_i.valid = 1'b0;
		stall_i = 1'b0;
		csr_flush_i = 1'b0;
		lookup_req_i = 1'b1;
		lookup_pc_i = pc;
		exp_valid = !flush_pending;
		flush_pending = 1'b0;
		exp = table_predict(pc);
		@(negedge clk);
		lookup_req_i = 1'b0;
		check_value("predict_valid", 32'(predict_valid_o), 32'(exp_valid));
		if (exp_valid) begin
			check_value("predict taken", 32'(predict_o.taken), 32'(exp.taken));
			check_value("predict npc", 32'(predict_o.npc), 32'(exp.npc));
			check_value("predict hit", 32'(predict_o.hit), 32'(exp.hit));
			if (exp.hit) begin
				check_value("predict class", 32'(predict_o.br_class), 32'(exp.br_class));
			end
		end
	endtask

	task automatic train_and_expect(logic [31:0] pc, logic taken, int times, logic want);
		repeat (times) resolve_branch(eq_branch(pc, taken), 1'b0, 1'b0, 32'd0);
		lookup_check(pc);
		if (!predict_valid_o) lookup_check(pc);
		check_value("trained direction", 32'(predict_o.taken), 32'(want));
		if (want) begin
			check_value("trained npc", 32'(predict_o.npc), (pc + 32'h40) >> 2);
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		bpu_resolve_t r;
		br_class_t    want;
		int           ready_cycles;
		logic [31:0]  p;
		void'($urandom(32'h697ea0ca));
		arst_n_i = 1'b0;
		lookup_req_i = 1'b0;
		lookup_pc_i = 32'd0;
		resolve_i = '0;
		stall_i = 1'b0;
		csr_flush_i = 1'b0;
		csr_target_i = 32'd0;
		for (int i = 0; i < ENTRIES; i++) begin
			m_cnt[i] = 2'd1;
			m_valid[i] = 1'b0;
			m_tag[i] = '0;
			m_tgt[i] = '0;
			m_cls[i] = BR_PC_RELATIVE;
		end
		repeat (8) @(negedge clk);
		arst_n_i = 1'b1;

		// Lookups requested during the clear sweep are ignored
		ready_cycles = 0;
		lookup_req_i = 1'b1;
		while (!ready_o) begin
			@(negedge clk);
			lookup_pc_i = $urandom;
			ready_cycles++;
		end
		lookup_req_i = 1'b0;
		check_value("cycles until ready", ready_cycles, ENTRIES);
		for (int i = 0; i < 8; i++) begin
			lookup_check($urandom);
		end

		// Compare opcodes with boundary operands
		for (int i = 0; i < 120; i++) begin
			r = random_branch(BRANCH_CONDITION);
			resolve_branch(r, 1'b0, 1'b0, 32'd0);
			lookup_check(r.pc);
		end

		// All kinds with stalls and CSR redirects mixed in
		for (int i = 0; i < 150; i++) begin
			r = random_branch(branch_type_t'(2'($urandom)));
			r.branch_link = $urandom_range(3) == 0;
			resolve_branch(r, $urandom_range(5) == 0, $urandom_range(7) == 0, $urandom);
			lookup_check(r.pc);
			if (!predict_valid_o) lookup_check(r.pc);
		end

		// One trained entry per branch class
		for (int k = 0; k < 5; k++) begin
			r = random_branch(BRANCH_IMMEDIATE);
			r.pc = 32'h0000_3000 + 32'(k) * 32'd4;
			want = BR_ABSOLUTE;
			case (k)
				0: begin
					r.branch_link = 1'b1;
					want = BR_CALL;
				end
				1: begin
					r.branch_type = BRANCH_INDIRECT;
					r.inst25_0[4:0] = 5'd1;
					want = BR_CALL;
				end
				2: begin
					r.branch_type = BRANCH_INDIRECT;
					r.inst25_0 = {16'd0, 5'd1, 5'd0};
					want = BR_RETURN;
				end
				3: want = BR_ABSOLUTE;
				default: begin
					r.branch_type = BRANCH_CONDITION;
					r.cmp_type = CMP_EQL;
					r.rd = r.rj;
					want = BR_PC_RELATIVE;
				end
			endcase
			r.predict = table_predict(r.pc);
			resolve_branch(r, 1'b0, 1'b0, 32'd0);
			lookup_check(r.pc);
			if (!predict_valid_o) lookup_check(r.pc);
			check_value("trained hit", 32'(predict_o.hit), 32'd1);
			check_value("trained class", 32'(predict_o.br_class), 32'(want));
		end

		// Counter walk on an index that may be warm from the random phase
		p = 32'h0040_0008;
		train_and_expect(p, 1'b0, 3, 1'b0);
		train_and_expect(p, 1'b1, 1, 1'b0);
		train_and_expect(p, 1'b1, 1, 1'b1);
		train_and_expect(p, 1'b1, 2, 1'b1);
		train_and_expect(p, 1'b0, 1, 1'b1);

		// Stalled mispredicts neither flush nor train
		for (int i = 0; i < 3; i++) begin
			resolve_branch(eq_branch(p, 1'b0), 1'b1, 1'b0, 32'd0);
		end
		train_and_expect(p, 1'b0, 0, 1'b1);
		train_and_expect(p, 1'b0, 1, 1'b0);

		// Lookups in the flush cycle
		resolve_branch(eq_branch(p, 1'b1), 1'b0, 1'b0, 32'd0);
		lookup_check(p);
		r = eq_branch(p, 1'b0);
		r.valid = 1'b0;
		resolve_branch(r, 1'b0, 1'b1, 32'h1234_5678);
		lookup_check(p);
		lookup_check(p);

		repeat (2) @(negedge clk);
		$display("Errors: %0d value checks, %0d property checks", err_cnt, prop_errs);
		if (err_cnt == 0 && prop_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : tb_bpu_top

`default_nettype wire

//--- verilog/bht.sv
/*
 * Bimodal direction table of 2-bit saturating counters
 * with registered read and a clear port
 */

`default_nettype none

module bht #(
	parameter int IDX_W = bpu_pkg::DEFAULT_IDX_W
) (
	input  wire logic             clk,
	input  wire logic             arst_n_i,
	input  wire logic             rd_en_i,
	input  wire logic [31:0]      rd_pc_i,
	output logic                  taken_o,
	input  wire logic             clear_i,
	input  wire logic [IDX_W-1:0] clear_idx_i,
	input  wire logic             we_i,
	input  wire logic [29:0]      wr_pc_i,
	input  wire logic             wr_taken_i
);

	localparam int ENTRIES = 2 ** IDX_W;

	logic [1:0]       cnt_q [ENTRIES];
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;
	logic [1:0]       wr_cnt;
	logic             taken_q;

	assign rd_idx = rd_pc_i[IDX_W+1:2];
	assign wr_idx = wr_pc_i[IDX_W-1:0];
	assign wr_cnt = cnt_q[wr_idx];

	// Counter array, swept by clear after reset
	always_ff @(posedge clk) begin
		if (clear_i) begin
			// Weakly not-taken
			cnt_q[clear_idx_i] <= 2'd1;
		end else if (we_i) begin
			if (wr_taken_i && wr_cnt != 2'd3) begin
				cnt_q[wr_idx] <= wr_cnt + 2'd1;
			end else if (!wr_taken_i && wr_cnt != 2'd0) begin
				cnt_q[wr_idx] <= wr_cnt - 2'd1;
			end
		end
	end

	// Registered read, upper bit is the direction
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			taken_q <= 1'b0;
		end else if (rd_en_i) begin
			taken_q <= cnt_q[rd_idx][1];
		end
	end

	assign taken_o = taken_q;

endmodule : bht

`default_nettype wire

//--- verilog/bpf.sv
/*
 * Branch feedback resolver: direction compare, target,
 * misprediction and flush, repair target, branch class, link value
 */

`default_nettype none

module bpf (
	input  wire bpu_pkg::bpu_resolve_t resolve_i,
	input  wire logic                  stall_i,
	input  wire logic                  csr_flush_i,
	input  wire logic [31:0]           csr_target_i,
	output bpu_pkg::bpu_update_t       update_o,
	output logic [31:0]                pc_link_o
);

	import bpu_pkg::*;

	logic        taken;
	logic        res_valid;
	logic [25:0] offs;
	logic [4:0]  rj_index;
	logic [4:0]  rd_index;
	logic [31:0] offs_26;
	logic [31:0] offs_16;
	logic [31:0] target;
	logic [29:0] repair_pc;
	logic        target_miss;
	logic        direction_miss;
	logic        predict_miss;

	assign offs     = resolve_i.inst25_0;
	assign rj_index = offs[9:5];
	assign rd_index = offs[4:0];

	// Offsets are word offsets, sign extended
	assign offs_26 = {{4{offs[9]}}, offs[9:0], offs[25:10], 2'b00};
	assign offs_16 = {{14{offs[25]}}, offs[25:10], 2'b00};

	// Resolve only counts when execute is not stalled
	assign res_valid = resolve_i.valid & ~stall_i;

	// ------------------------------------------------------------
	// Direction
	// ------------------------------------------------------------
	always_comb begin
		taken = 1'b0;
		if (resolve_i.branch_type == BRANCH_CONDITION) begin
			case (resolve_i.cmp_type)
				CMP_EQL: taken = resolve_i.rj == resolve_i.rd;
				CMP_NEQ: taken = resolve_i.rj != resolve_i.rd;
				CMP_LSS: taken = $signed(resolve_i.rj) <  $signed(resolve_i.rd);
				CMP_GER: taken = $signed(resolve_i.rj) >  $signed(resolve_i.rd);
				CMP_LEQ: taken = $signed(resolve_i.rj) <= $signed(resolve_i.rd);
				CMP_GEQ: taken = $signed(resolve_i.rj) >= $signed(resolve_i.rd);
				CMP_LTU: taken = resolve_i.rj <  resolve_i.rd;
				CMP_GEU: taken = resolve_i.rj >= resolve_i.rd;
				default: taken = 1'b0;
			endcase
		end else if (resolve_i.branch_type != BRANCH_INVALID) begin
			taken = 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Target
	// ------------------------------------------------------------
	always_comb begin
		if (resolve_i.branch_type == BRANCH_IMMEDIATE) begin
			target = resolve_i.pc + offs_26;
		end else if (resolve_i.branch_type == BRANCH_INDIRECT) begin
			target = resolve_i.rj + offs_16;
		end else if (resolve_i.branch_type == BRANCH_CONDITION && taken) begin
			target = resolve_i.pc + offs_16;
		end else begin
			// Next 8-byte fetch group
			target = {resolve_i.pc[31:3] + 29'd1, 3'b000};
		end
	end

	assign target_miss    = resolve_i.predict.npc != target[31:2];
	assign direction_miss = resolve_i.predict.taken != taken;
	assign predict_miss   = (target_miss & resolve_i.predict.taken) | direction_miss;

	// Slot 0 falsely taken skips slot 1, so refetch it
	assign repair_pc = resolve_i.pc[31:2] + 30'd1;

	always_comb begin
		update_o.flush    = (res_valid & predict_miss) | csr_flush_i;
		update_o.br_taken = taken;
		update_o.pc       = resolve_i.pc[31:2];
		update_o.write    = res_valid & (resolve_i.branch_type != BRANCH_INVALID);
		if (csr_flush_i) begin
			update_o.br_target = csr_target_i[31:2];
		end else if (!resolve_i.pc[2] && !taken && resolve_i.predict.taken) begin
			update_o.br_target = repair_pc;
		end else begin
			update_o.br_target = target[31:2];
		end
		// Class for the BTB entry
		if ((resolve_i.branch_type == BRANCH_INDIRECT && rd_index == 5'd1) ||
		    resolve_i.branch_link) begin
			update_o.br_class = BR_CALL;
		end else if (resolve_i.branch_type == BRANCH_INDIRECT && rj_index == 5'd1 &&
		             offs_16 == 32'd0) begin
			update_o.br_class = BR_RETURN;
		end else if (resolve_i.branch_type == BRANCH_IMMEDIATE ||
		             resolve_i.branch_type == BRANCH_INDIRECT) begin
			update_o.br_class = BR_ABSOLUTE;
		end else begin
			update_o.br_class = BR_PC_RELATIVE;
		end
	end

	assign pc_link_o = resolve_i.pc + 32'd4;

endmodule : bpf

`default_nettype wire

//--- verilog/bpu_ctrl.sv
/*
 * Controller FSM: post-reset clear sweep of both tables,
 * then lookup and training enables, one-cycle flush state
 */

`default_nettype none

module bpu_ctrl #(
	parameter int IDX_W = bpu_pkg::DEFAULT_IDX_W
) (
	input  wire logic             clk,
	input  wire logic             arst_n_i,
	input  wire logic             flush_i,
	input  wire logic             write_i,
	output logic                  clear_o,
	output logic [IDX_W-1:0]      clear_idx_o,
	output logic                  ready_o,
	output logic                  tbl_we_o,
	output logic                  lookup_ok_o
);

	import bpu_pkg::*;

	ctrl_state_t      state_q;
	ctrl_state_t      state_d;
	logic [IDX_W-1:0] idx_q;
	logic             sweep_done;

	assign sweep_done = &idx_q;

	// ------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_CLEAR: if (sweep_done) state_d = ST_RUN;
			ST_RUN:   if (flush_i) state_d = ST_FLUSH;
			// Back-to-back flushes keep lookups blocked
			ST_FLUSH: state_d = flush_i ? ST_FLUSH : ST_RUN;
			default:  state_d = ST_CLEAR;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_CLEAR;
			idx_q   <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_CLEAR) begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	// Outputs decoded from state
	assign clear_o     = state_q == ST_CLEAR;
	assign clear_idx_o = idx_q;
	assign ready_o     = state_q != ST_CLEAR;
	assign lookup_ok_o = state_q == ST_RUN;
	// Training goes on during the flush cycle too
	assign tbl_we_o    = ready_o & write_i;

endmodule : bpu_ctrl

`default_nettype wire

//--- verilog/bpu_pkg.sv
/*
 * Shared definitions for the branch prediction unit:
 * branch, compare, class and controller state enums,
 * prediction, resolve and table update structs, default table size
 */

`default_nettype none

package bpu_pkg;

	// Default table index width, 64 entries
	localparam int DEFAULT_IDX_W = 6;

	// ------------------------------------------------------------
	// Enums
	// ------------------------------------------------------------

	// Branch kind as decoded for execute
	typedef enum logic [1:0] {
		BRANCH_INVALID   = 2'd0,
		BRANCH_CONDITION = 2'd1,
		BRANCH_IMMEDIATE = 2'd2,
		BRANCH_INDIRECT  = 2'd3
	} branch_type_t;

	// Compare opcode of a conditional branch
	typedef enum logic [2:0] {
		CMP_EQL = 3'd0,
		CMP_NEQ = 3'd1,
		CMP_LSS = 3'd2,
		CMP_GER = 3'd3,
		CMP_LEQ = 3'd4,
		CMP_GEQ = 3'd5,
		CMP_LTU = 3'd6,
		CMP_GEU = 3'd7
	} cmp_type_t;

	// Class kept in the BTB next to the target
	typedef enum logic [1:0] {
		BR_PC_RELATIVE = 2'd0,
		BR_ABSOLUTE    = 2'd1,
		BR_CALL        = 2'd2,
		BR_RETURN      = 2'd3
	} br_class_t;

	// Controller states
	typedef enum logic [1:0] {
		ST_CLEAR = 2'd0,
		ST_RUN   = 2'd1,
		ST_FLUSH = 2'd2
	} ctrl_state_t;

	// ------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------

	// Prediction travelling with a fetched instruction, npc is a word address
	typedef struct packed {
		logic        taken;
		logic [29:0] npc;
		logic        hit;
		br_class_t   br_class;
	} bpu_predict_t;

	// Branch as presented by execute
	typedef struct packed {
		logic         valid;
		logic [31:0]  pc;
		logic [31:0]  rj;
		logic [31:0]  rd;
		logic [25:0]  inst25_0;
		branch_type_t branch_type;
		cmp_type_t    cmp_type;
		logic         branch_link;
		bpu_predict_t predict;
	} bpu_resolve_t;

	// Resolver result, also the table write port
	typedef struct packed {
		logic        flush;
		logic        br_taken;
		logic [29:0] pc;
		logic [29:0] br_target;
		br_class_t   br_class;
		logic        write;
	} bpu_update_t;

endpackage : bpu_pkg

`default_nettype wire

//--- verilog/bpu_top.sv
/*
 * Branch prediction unit top level: controller, BHT, BTB,
 * feedback resolver, registered prediction for fetch
 */

`default_nettype none

module bpu_top #(
	parameter int IDX_W = bpu_pkg::DEFAULT_IDX_W
) (
	input  wire logic                  clk,
	input  wire logic                  arst_n_i,
	// Fetch side
	input  wire logic                  lookup_req_i,
	input  wire logic [31:0]           lookup_pc_i,
	output logic                       predict_valid_o,
	output bpu_pkg::bpu_predict_t      predict_o,
	// Execute side
	input  wire bpu_pkg::bpu_resolve_t resolve_i,
	input  wire logic                  stall_i,
	input  wire logic                  csr_flush_i,
	input  wire logic [31:0]           csr_target_i,
	output bpu_pkg::bpu_update_t       update_o,
	output logic [31:0]                pc_link_o,
	output logic                       ready_o
);

	import bpu_pkg::*;

	logic             clear;
	logic [IDX_W-1:0] clear_idx;
	logic             tbl_we;
	logic             lookup_ok;
	logic             rd_en;
	logic             btb_we;
	logic             bht_taken;
	logic             btb_hit;
	logic [29:0]      btb_target;
	br_class_t        btb_class;
	logic             valid_q;
	logic [31:0]      pc_q;
	logic             pred_taken;

	assign rd_en = lookup_req_i & lookup_ok;
	// BTB only learns real taken targets, never a CSR redirect
	assign btb_we = tbl_we & update_o.br_taken & ~csr_flush_i;

	bpu_ctrl #(.IDX_W(IDX_W)) i_bpu_ctrl (
		.clk, .arst_n_i,
		.flush_i     (update_o.flush),
		.write_i     (update_o.write),
		.clear_o     (clear),
		.clear_idx_o (clear_idx),
		.ready_o,
		.tbl_we_o    (tbl_we),
		.lookup_ok_o (lookup_ok)
	);

	bht #(.IDX_W(IDX_W)) i_bht (
		.clk, .arst_n_i,
		.rd_en_i     (rd_en),
		.rd_pc_i     (lookup_pc_i),
		.taken_o     (bht_taken),
		.clear_i     (clear),
		.clear_idx_i (clear_idx),
		.we_i        (tbl_we),
		.wr_pc_i     (update_o.pc),
		.wr_taken_i  (update_o.br_taken)
	);

	btb #(.IDX_W(IDX_W)) i_btb (
		.clk, .arst_n_i,
		.rd_en_i     (rd_en),
		.rd_pc_i     (lookup_pc_i),
		.hit_o       (btb_hit),
		.target_o    (btb_target),
		.class_o     (btb_class),
		.clear_i     (clear),
		.clear_idx_i (clear_idx),
		.we_i        (btb_we),
		.wr_pc_i     (update_o.pc),
		.wr_target_i (update_o.br_target),
		.wr_class_i  (update_o.br_class)
	);

	bpf i_bpf (
		.resolve_i, .stall_i, .csr_flush_i, .csr_target_i,
		.update_o, .pc_link_o
	);

	// ------------------------------------------------------------
	// Prediction register
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= rd_en;
		end
	end

	// Lookup pc for the fall-through npc
	always_ff @(posedge clk) begin
		if (rd_en) begin
			pc_q <= lookup_pc_i;
		end
	end

	assign pred_taken         = btb_hit & bht_taken;
	assign predict_valid_o    = valid_q;
	assign predict_o.taken    = pred_taken;
	assign predict_o.npc      = pred_taken ? btb_target : {pc_q[31:3] + 29'd1, 1'b0};
	assign predict_o.hit      = btb_hit;
	assign predict_o.br_class = btb_class;

endmodule : bpu_top

`default_nettype wire

//--- verilog/btb.sv
/*
 * Direct-mapped branch target buffer: valid, tag, target and class
 * per entry, registered tag compare and read, clear port
 */

`default_nettype none

module btb #(
	parameter int IDX_W = bpu_pkg::DEFAULT_IDX_W
) (
	input  wire logic                clk,
	input  wire logic                arst_n_i,
	input  wire logic                rd_en_i,
	input  wire logic [31:0]         rd_pc_i,
	output logic                     hit_o,
	output logic [29:0]              target_o,
	output bpu_pkg::br_class_t       class_o,
	input  wire logic                clear_i,
	input  wire logic [IDX_W-1:0]    clear_idx_i,
	input  wire logic                we_i,
	input  wire logic [29:0]         wr_pc_i,
	input  wire logic [29:0]         wr_target_i,
	input  wire bpu_pkg::br_class_t  wr_class_i
);

	import bpu_pkg::*;

	localparam int ENTRIES = 2 ** IDX_W;
	localparam int TAG_W   = 30 - IDX_W;

	logic [ENTRIES-1:0] valid_q;
	logic [TAG_W-1:0]   tag_q [ENTRIES];
	logic [29:0]        target_q [ENTRIES];
	br_class_t          class_q [ENTRIES];

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;
	logic             hit_q;
	logic [29:0]      rd_target_q;
	br_class_t        rd_class_q;

	assign rd_idx = rd_pc_i[IDX_W+1:2];
	assign rd_tag = rd_pc_i[31:IDX_W+2];
	assign wr_idx = wr_pc_i[IDX_W-1:0];

	// ------------------------------------------------------------
	// Entry state
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;
		end else if (clear_i) begin
			valid_q[clear_idx_i] <= 1'b0;
		end else if (we_i) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// Payload, only meaningful behind valid
	always_ff @(posedge clk) begin
		if (we_i && !clear_i) begin
			tag_q[wr_idx]    <= wr_pc_i[29:IDX_W];
			target_q[wr_idx] <= wr_target_i;
			class_q[wr_idx]  <= wr_class_i;
		end
	end

	// ------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hit_q <= 1'b0;
		end else if (rd_en_i) begin
			hit_q <= valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			rd_target_q <= target_q[rd_idx];
			rd_class_q  <= class_q[rd_idx];
		end
	end

	assign hit_o    = hit_q;
	assign target_o = rd_target_q;
	assign class_o  = rd_class_q;

endmodule : btb

`default_nettype wire
